// ==== dsp_bus_pkg.sv ====
`default_nettype none

// register bus of the router, one request per strobe
package dsp_bus_pkg;

   typedef struct packed {
      logic [31:0] addr;    // offset in 15:0, channel index above
      logic [31:0] wdata;
      logic        wen;     // write strobe
      logic        ren;     // read strobe
   } bus_req_t;

   typedef struct packed {
      logic [31:0] rdata;
      logic        ack;     // one cycle after the strobe
      logic        err;     // held low
   } bus_rsp_t;

   //////////////////////////////////////////////////
   // register offsets, addr[15:0]

   localparam logic [15:0] OFS_IN_SEL  = 16'h0000;   // route.src
   localparam logic [15:0] OFS_OUT_SEL = 16'h0004;   // route.dac
   localparam logic [15:0] OFS_SAT     = 16'h0008;   // {sat_b, sat_a}
   localparam logic [15:0] OFS_SRC     = 16'h0010;   // raw source value

   localparam int IDX_LSB = 16;   // channel index starts here

endpackage

`default_nettype wire

// ==== dsp_ctrl_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module dsp_ctrl_regs #(
   parameter int SLOTS = 4
) (
   input  wire                                   clk_i,
   input  wire                                   rstn_i,
   input  wire dsp_bus_pkg::bus_req_t            bus_i,
   output dsp_bus_pkg::bus_rsp_t                 bus_o,
   output dsp_sig_pkg::route_t [SLOTS+3:0]       routes_o,    // one per routed channel
   input  wire dsp_sig_pkg::sample_t [SLOTS+5:0] src_vals_i,  // source table, readback
   input  wire                                   sat_a_i,
   input  wire                                   sat_b_i
);

   localparam int CHANS = SLOTS + 4;   // slots, scope/gen pair, pwm pair
   localparam int SRCS  = SLOTS + 6;   // slots, gens, adcs, dacs
   localparam int IDX_W = 4;           // addr[19:16]
   localparam int SEL_W = dsp_sig_pkg::SEL_W;
   localparam int SMP_W = dsp_sig_pkg::SAMPLE_W;

   // default sources
   localparam dsp_sig_pkg::src_sel_t SRC_ADC1 = dsp_sig_pkg::src_sel_t'(SLOTS + 2);
   localparam dsp_sig_pkg::src_sel_t SRC_ADC2 = dsp_sig_pkg::src_sel_t'(SLOTS + 3);

   dsp_sig_pkg::route_t [CHANS-1:0] route_q;   // routing table
   logic [15:0]                     ofs;
   logic [IDX_W-1:0]                idx;
   logic                            bus_en;
   logic [31:0]                     rdata_d;
   logic [31:0]                     rdata_q;
   logic                            ack_q;

   assign ofs    = bus_i.addr[15:0];
   assign idx    = bus_i.addr[dsp_bus_pkg::IDX_LSB +: IDX_W];
   assign bus_en = bus_i.wen | bus_i.ren;   // read or write, one request

   //////////////////////////////////////////////////
   // routing table and write decode

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         for (int c = 0; c < CHANS; c++) begin
            route_q[c].src <= SRC_ADC1;   // slots and scope1 watch adc1
            route_q[c].dac <= '0;         // nothing summed into the dacs
         end
         route_q[SLOTS+1].src <= SRC_ADC2;   // scope2
         route_q[SLOTS+2].src <= dsp_sig_pkg::SRC_NONE;   // pwm0 off
         route_q[SLOTS+3].src <= dsp_sig_pkg::SRC_NONE;   // pwm1 off
      end else if (bus_i.wen && (idx < CHANS)) begin
         if (ofs == dsp_bus_pkg::OFS_IN_SEL) begin
            route_q[idx].src <= bus_i.wdata[SEL_W-1:0];
         end
         // pwm channels have no direct output
         if ((ofs == dsp_bus_pkg::OFS_OUT_SEL) && (idx < SLOTS + 2)) begin
            route_q[idx].dac <= bus_i.wdata[1:0];
         end
      end
   end

   assign routes_o = route_q;

   //////////////////////////////////////////////////
   // read mux

   always_comb begin
      rdata_d = '0;   // unmapped reads answer zero
      case (ofs)
         dsp_bus_pkg::OFS_IN_SEL: begin
            if (idx < CHANS) begin
               rdata_d = {{(32-SEL_W){1'b0}}, route_q[idx].src};
            end
         end
         dsp_bus_pkg::OFS_OUT_SEL: begin
            if (idx < CHANS) begin
               rdata_d = {30'b0, route_q[idx].dac};
            end
         end
         dsp_bus_pkg::OFS_SAT: begin
            rdata_d = {30'b0, sat_b_i, sat_a_i};
         end
         dsp_bus_pkg::OFS_SRC: begin
            // raw bits, no sign extension
            if (idx < SRCS) begin
               rdata_d = {{(32-SMP_W){1'b0}}, src_vals_i[idx]};
            end
         end
         default: begin
            rdata_d = '0;
         end
      endcase
   end

   //////////////////////////////////////////////////
   // response, one cycle after the strobe

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= bus_en;   // no back-pressure
      end
   end

   always_ff @(posedge clk_i) begin
      rdata_q <= rdata_d;
   end

   assign bus_o = '{rdata: rdata_q, ack: ack_q, err: 1'b0};

endmodule

`default_nettype wire

// ==== dsp_dac_sum.sv ====
`timescale 1ns/1ps
`default_nettype none

module dsp_dac_sum #(
   parameter int SLOTS = 4
) (
   input  wire                                   clk_i,
   input  wire                                   rstn_i,
   input  wire dsp_sig_pkg::sample_t [SLOTS+1:0] direct_i,   // slot returns, then gens
   input  wire                       [SLOTS+1:0] enable_i,   // out1 or out2 bit per channel
   output dsp_sig_pkg::sample_t                  dac_o,
   output logic                                  sat_o
);

   localparam int LANES  = 8;   // tree width, unused lanes stay zero
   localparam int SMP_W  = dsp_sig_pkg::SAMPLE_W;
   localparam int SEL_W  = dsp_sig_pkg::SEL_W;
   localparam int SUM_W  = $bits(dsp_sig_pkg::sum_t);

   dsp_sig_pkg::sample_t [LANES-1:0] dir_pad;   // direct samples padded to 8
   logic [LANES-1:0]                 en_pad;
   dsp_sig_pkg::sum_t [LANES-1:0]    lane;      // masked, sign extended
   dsp_sig_pkg::sum_t [LANES/2-1:0]  pair_q;    // stage 1
   dsp_sig_pkg::sum_t [1:0]          quad_q;    // stage 2
   dsp_sig_pkg::sum_t                total_q;   // stage 3
   logic                             ovf;
   dsp_sig_pkg::sample_t             clip;
   dsp_sig_pkg::sample_t             dac_q;     // stage 4
   logic                             sat_q;

   assign dir_pad = (LANES*SMP_W)'(direct_i);
   assign en_pad  = LANES'(enable_i);

   // zero every disabled lane before the tree
   always_comb begin
      for (int i = 0; i < LANES; i++) begin
         if (en_pad[i]) begin
            lane[i] = {{SEL_W{dir_pad[i][SMP_W-1]}}, dir_pad[i]};
         end else begin
            lane[i] = '0;
         end
      end
   end

   //////////////////////////////////////////////////
   // registered adder tree, a new sample every cycle

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         pair_q  <= '0;
         quad_q  <= '0;
         total_q <= '0;
         dac_q   <= '0;
         sat_q   <= 1'b0;
      end else begin
         for (int i = 0; i < LANES/2; i++) begin
            pair_q[i] <= lane[2*i] + lane[2*i+1];
         end
         quad_q[0] <= pair_q[0] + pair_q[1];
         quad_q[1] <= pair_q[2] + pair_q[3];
         total_q   <= quad_q[0] + quad_q[1];   // 8 samples fit in 18 bits
         dac_q     <= clip;
         sat_q     <= ovf;                     // flag lines up with the clipped sample
      end
   end

   //////////////////////////////////////////////////
   // saturation to the sample range

   // out of range when the bits above the sample msb disagree with the sign
   assign ovf  = (total_q[SUM_W-1:SMP_W-1] != '0) && (total_q[SUM_W-1:SMP_W-1] != '1);
   assign clip = ovf ? {total_q[SUM_W-1], {(SMP_W-1){~total_q[SUM_W-1]}}}   // max or min
                     : total_q[SMP_W-1:0];

   assign dac_o = dac_q;
   assign sat_o = sat_q;

endmodule

`default_nettype wire

// ==== dsp_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module dsp_router #(
   parameter int SLOTS = 4   // processing slots
) (
   input  wire                                   clk_i,
   input  wire                                   rstn_i,
   input  wire dsp_sig_pkg::sample_t             adc_a_i,
   input  wire dsp_sig_pkg::sample_t             adc_b_i,
   input  wire dsp_sig_pkg::sample_t [1:0]       gen_i,        // generator samples
   input  wire dsp_sig_pkg::sample_t [SLOTS-1:0] slot_ret_i,   // returns from the slots
   output dsp_sig_pkg::sample_t [SLOTS-1:0]      slot_sig_o,   // selected slot inputs
   output dsp_sig_pkg::sample_t [1:0]            scope_o,
   output dsp_sig_pkg::sample_t [1:0]            pwm_o,
   output dsp_sig_pkg::sample_t                  dat_a_o,      // dac1
   output dsp_sig_pkg::sample_t                  dat_b_o,      // dac2
   input  wire dsp_bus_pkg::bus_req_t            bus_i,
   output dsp_bus_pkg::bus_rsp_t                 bus_o
);

   wire dsp_sig_pkg::route_t  [SLOTS+3:0] routes;
   wire dsp_sig_pkg::sample_t [SLOTS+5:0] src_vals;
   wire dsp_sig_pkg::sample_t [SLOTS+3:0] chan_sig;
   wire dsp_sig_pkg::sample_t [SLOTS+1:0] direct;   // slot returns double as direct outputs
   wire [SLOTS+1:0]                       en_a;
   wire [SLOTS+1:0]                       en_b;
   wire                                   sat_a;
   wire                                   sat_b;

   assign direct = {gen_i, slot_ret_i};

   for (genvar c = 0; c < SLOTS + 2; c++) begin : g_en
      assign en_a[c] = routes[c].dac.out1;
      assign en_b[c] = routes[c].dac.out2;
   end

   // channel order: slots, scope pair, pwm pair
   assign slot_sig_o = chan_sig[SLOTS-1:0];
   assign scope_o    = chan_sig[SLOTS+1:SLOTS];
   assign pwm_o      = chan_sig[SLOTS+3:SLOTS+2];

   //////////////////////////////////////////////////
   // blocks

   dsp_ctrl_regs #(.SLOTS(SLOTS)) u_regs (
      .clk_i(clk_i), .rstn_i(rstn_i), .bus_i(bus_i), .bus_o(bus_o),
      .routes_o(routes), .src_vals_i(src_vals), .sat_a_i(sat_a), .sat_b_i(sat_b)
   );

   dsp_source_mux #(.SLOTS(SLOTS)) u_mux (
      .routes_i(routes), .slot_ret_i(slot_ret_i), .gen_i(gen_i),
      .adc_a_i(adc_a_i), .adc_b_i(adc_b_i), .dac_a_i(dat_a_o), .dac_b_i(dat_b_o),
      .src_vals_o(src_vals), .chan_sig_o(chan_sig)
   );

   dsp_dac_sum #(.SLOTS(SLOTS)) u_sum_a (
      .clk_i(clk_i), .rstn_i(rstn_i), .direct_i(direct), .enable_i(en_a),
      .dac_o(dat_a_o), .sat_o(sat_a)
   );

   dsp_dac_sum #(.SLOTS(SLOTS)) u_sum_b (
      .clk_i(clk_i), .rstn_i(rstn_i), .direct_i(direct), .enable_i(en_b),
      .dac_o(dat_b_o), .sat_o(sat_b)
   );

endmodule

`default_nettype wire

// ==== dsp_sig_pkg.sv ====
`default_nettype none

// sample, sum and routing types of the signal router
package dsp_sig_pkg;

   //////////////////////////////////////////////////
   // widths

   localparam int SAMPLE_W = 14;   // adc/dac sample width
   localparam int SEL_W    = 4;    // source code width, 16 codes

   //////////////////////////////////////////////////
   // data types

   typedef logic signed [SAMPLE_W-1:0] sample_t;
   // one sample widened for the adder tree
   typedef logic signed [SAMPLE_W+SEL_W-1:0] sum_t;

   typedef logic [SEL_W-1:0] src_sel_t;   // source code

   // last code is no source, selecting it gives zero
   localparam src_sel_t SRC_NONE = src_sel_t'(2**SEL_W - 1);

   // direct output destination of one channel
   typedef struct packed {
      logic out2;   // add into dac2
      logic out1;   // add into dac1
   } dac_sel_t;

   // full routing of one channel, 6 bits
   typedef struct packed {
      src_sel_t src;   // which source feeds the input
      dac_sel_t dac;   // where the direct output goes
   } route_t;

endpackage

`default_nettype wire

// ==== dsp_source_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module dsp_source_mux #(
   parameter int SLOTS = 4
) (
   input  wire dsp_sig_pkg::route_t  [SLOTS+3:0] routes_i,
   input  wire dsp_sig_pkg::sample_t [SLOTS-1:0] slot_ret_i,  // slot returns
   input  wire dsp_sig_pkg::sample_t [1:0]       gen_i,       // generator 1, 2
   input  wire dsp_sig_pkg::sample_t             adc_a_i,
   input  wire dsp_sig_pkg::sample_t             adc_b_i,
   input  wire dsp_sig_pkg::sample_t             dac_a_i,     // fed back from the summers
   input  wire dsp_sig_pkg::sample_t             dac_b_i,
   output dsp_sig_pkg::sample_t [SLOTS+5:0]      src_vals_o,  // table in code order
   output dsp_sig_pkg::sample_t [SLOTS+3:0]      chan_sig_o   // selected input per channel
);

   localparam int CHANS = SLOTS + 4;
   localparam int SRCS  = SLOTS + 6;

   //////////////////////////////////////////////////
   // source table
   //   0..SLOTS-1      slot returns
   //   SLOTS, +1       generators
   //   SLOTS+2, +3     adcs
   //   SLOTS+4, +5     dacs

   assign src_vals_o = {
      dac_b_i,
      dac_a_i,
      adc_b_i,
      adc_a_i,
      gen_i,
      slot_ret_i   // lowest codes
   };

   //////////////////////////////////////////////////
   // per channel select

   always_comb begin
      for (int c = 0; c < CHANS; c++) begin
         if ((routes_i[c].src != dsp_sig_pkg::SRC_NONE) &&
             (routes_i[c].src < SRCS)) begin
            chan_sig_o[c] = src_vals_o[routes_i[c].src];
         end else begin
            chan_sig_o[c] = '0;   // no source or code past the table
         end
      end
   end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the router testbench with verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_dsp_router \
   -f verilog.f -o tb_dsp_router
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/tb_dsp_router > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Checks failed" "$LOG"; then
   exit 1
fi
exit 0

// ==== tb_dsp_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dsp_router;

   localparam int SLOTS   = 4;
   localparam int CHANS   = SLOTS + 4;      // slots, scope pair, pwm pair
   localparam int DIRECT  = SLOTS + 2;      // slot returns and generators
   localparam int SRCS    = SLOTS + 6;
   localparam int RAND_IT = 64;             // random dac cycles
   localparam int SMAX    = 8191;
   localparam int SMIN    = -8192;
   // reset, defaults, bus, routing, random sums, clipping
   localparam int RUN_CYCLES = 8 + 2*CHANS + 4 + 3*(CHANS+2) + 2 + DIRECT + RAND_IT + 40;

   logic                              clk_i;
   logic                              rstn_i;
   dsp_sig_pkg::sample_t              adc_a;
   dsp_sig_pkg::sample_t              adc_b;
   dsp_sig_pkg::sample_t [1:0]        gen;
   dsp_sig_pkg::sample_t [SLOTS-1:0]  slot_ret;
   dsp_sig_pkg::sample_t [SLOTS-1:0]  slot_sig;
   dsp_sig_pkg::sample_t [1:0]        scope;
   dsp_sig_pkg::sample_t [1:0]        pwm;
   dsp_sig_pkg::sample_t              dat_a;
   dsp_sig_pkg::sample_t              dat_b;
   dsp_bus_pkg::bus_req_t             bus_req;
   dsp_bus_pkg::bus_rsp_t             bus_rsp;

   int                                errors = 0;
   integer                            seed   = 32'h2673;
   logic                              req_q;    // request seen at the last edge
   logic [DIRECT-1:0]                 en1_q;    // shadow of out1 bits
   logic [DIRECT-1:0]                 en2_q;    // shadow of out2 bits
   dsp_sig_pkg::sample_t [3:0]        pipe_a;   // expected dac1, [3] is due now
   dsp_sig_pkg::sample_t [3:0]        pipe_b;

   dsp_router #(.SLOTS(SLOTS)) UUT (
      .clk_i(clk_i), .rstn_i(rstn_i), .adc_a_i(adc_a), .adc_b_i(adc_b),
      .gen_i(gen), .slot_ret_i(slot_ret), .slot_sig_o(slot_sig), .scope_o(scope),
      .pwm_o(pwm), .dat_a_o(dat_a), .dat_b_o(dat_b), .bus_i(bus_req), .bus_o(bus_rsp)
   );

   initial begin
      clk_i = 1'b0;
      forever #4 clk_i = ~clk_i;   // 8 ns
   end

   //////////////////////////////////////////////////
   // reference model of the dac path

   // sum of enabled direct samples for one dac
   function automatic int direct_sum(input logic [DIRECT-1:0] en);
      int s;
      s = 0;
      for (int i = 0; i < DIRECT; i++) begin
         if (en[i]) begin
            s += (i < SLOTS) ? int'($signed(slot_ret[i])) : int'($signed(gen[i-SLOTS]));
         end
      end
      return s;
   endfunction

   function automatic dsp_sig_pkg::sample_t clip_sample(input int s);
      if (s > SMAX) begin
         return dsp_sig_pkg::sample_t'(SMAX);
      end else if (s < SMIN) begin
         return dsp_sig_pkg::sample_t'(SMIN);
      end
      return dsp_sig_pkg::sample_t'(s);
   endfunction

   always @(posedge clk_i) begin
      if (!rstn_i) begin
         req_q  <= 1'b0;
         en1_q  <= '0;
         en2_q  <= '0;
         pipe_a <= '0;
         pipe_b <= '0;
      end else begin
         req_q <= bus_req.wen | bus_req.ren;
         for (int i = 0; i < DIRECT; i++) begin
            if (bus_req.wen && (bus_req.addr[15:0] == dsp_bus_pkg::OFS_OUT_SEL) &&
                (bus_req.addr[19:16] == 4'(i))) begin
               en1_q[i] <= bus_req.wdata[0];
               en2_q[i] <= bus_req.wdata[1];
            end
         end
         pipe_a <= {pipe_a[2:0], clip_sample(direct_sum(en1_q))};   // old enables, like the dut
         pipe_b <= {pipe_b[2:0], clip_sample(direct_sum(en2_q))};
      end
   end

   //////////////////////////////////////////////////
   // assertions

   assert property (@(posedge clk_i) disable iff (!rstn_i) bus_rsp.ack == req_q)
      else begin
         errors++;
         $display("Mismatch: bus_o.ack got %h expected %h",
                  $sampled(bus_rsp.ack), $sampled(req_q));
      end

   assert property (@(posedge clk_i) disable iff (!rstn_i) bus_rsp.err == 1'b0)
      else begin
         errors++;
         $display("Mismatch: bus_o.err got %h expected 0", $sampled(bus_rsp.err));
      end

   assert property (@(posedge clk_i) disable iff (!rstn_i) dat_a == pipe_a[3])
      else begin
         errors++;
         $display("Mismatch: dat_a_o got %h expected %h", $sampled(dat_a), $sampled(pipe_a[3]));
      end

   assert property (@(posedge clk_i) disable iff (!rstn_i) dat_b == pipe_b[3])
      else begin
         errors++;
         $display("Mismatch: dat_b_o got %h expected %h", $sampled(dat_b), $sampled(pipe_b[3]));
      end

   //////////////////////////////////////////////////
   // helpers

   function automatic dsp_sig_pkg::sample_t src_value(input int code);
      if (code < SLOTS) begin
         return slot_ret[code];
      end
      case (code - SLOTS)
         0: return gen[0];
         1: return gen[1];
         2: return adc_a;
         3: return adc_b;
         4: return pipe_a[3];   // dac feedback
         5: return pipe_b[3];
         default: return '0;    // none or past the table
      endcase
   endfunction

   function automatic dsp_sig_pkg::sample_t chan_out(input int ch);
      if (ch < SLOTS) begin
         return slot_sig[ch];
      end else if (ch < SLOTS + 2) begin
         return scope[ch-SLOTS];
      end
      return pwm[ch-SLOTS-2];
   endfunction

   // port name of a routed channel
   function automatic string chan_name(input int ch);
      if (ch < SLOTS) begin
         return $sformatf("slot_sig_o[%0d]", ch);
      end else if (ch < SLOTS + 2) begin
         return $sformatf("scope_o[%0d]", ch - SLOTS);
      end
      return $sformatf("pwm_o[%0d]", ch - SLOTS - 2);
   endfunction

   task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else begin
         errors++;
         $display("Mismatch: %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_sample(input string name, input dsp_sig_pkg::sample_t got,
                               input dsp_sig_pkg::sample_t exp);
      assert (got === exp) else begin
         errors++;
         $display("Mismatch: %s got %h expected %h", name, got, exp);
      end
   endtask

   // one request at a falling edge, ack due at the next one
   task automatic bus_access(input logic wr, input logic [15:0] ofs, input int idx,
                             input logic [31:0] wdata, output logic [31:0] rdata);
      bus_req.addr  = {12'h000, idx[3:0], ofs};
      bus_req.wdata = wdata;
      bus_req.wen   = wr;
      bus_req.ren   = !wr;
      @(posedge clk_i);
      @(negedge clk_i);
      check_value("bus_o.ack", {31'b0, bus_rsp.ack}, 32'h1);
      check_value("bus_o.err", {31'b0, bus_rsp.err}, 32'h0);
      rdata         = bus_rsp.rdata;
      bus_req.wen   = 1'b0;   // idle unless the caller goes on
      bus_req.ren   = 1'b0;
   endtask

   task automatic write_reg(input logic [15:0] ofs, input int idx, input logic [31:0] wdata);
      logic [31:0] unused;
      bus_access(1'b1, ofs, idx, wdata, unused);
   endtask

   task automatic read_check(input logic [15:0] ofs, input int idx, input logic [31:0] exp,
                             input string name);
      logic [31:0] rdata;
      bus_access(1'b0, ofs, idx, 32'h0, rdata);
      check_value($sformatf("bus_o.rdata (%s)", name), rdata, exp);
   endtask

   // src write, output from the next cycle on, then readback of the source
   task automatic route_source(input int ch, input int code);
      write_reg(dsp_bus_pkg::OFS_IN_SEL, ch, code);
      check_sample(chan_name(ch), chan_out(ch), src_value(code));
      @(negedge clk_i);
      check_sample(chan_name(ch), chan_out(ch), src_value(code));
      read_check(dsp_bus_pkg::OFS_SRC, code, {18'b0, src_value(code)}, "src readback");
   endtask

   task automatic drive_random();
      for (int i = 0; i < SLOTS; i++) begin
         slot_ret[i] = dsp_sig_pkg::sample_t'($random(seed));
      end
      gen[0] = dsp_sig_pkg::sample_t'($random(seed));
      gen[1] = dsp_sig_pkg::sample_t'($random(seed));
   endtask

   task automatic fill_direct(input dsp_sig_pkg::sample_t v);
      for (int i = 0; i < SLOTS; i++) begin
         slot_ret[i] = v;
      end
      gen[0] = v;
      gen[1] = v;
      repeat (5) @(negedge clk_i);   // four stages plus one
   endtask

   //////////////////////////////////////////////////
   // stimulus

   initial begin
      int exp_src;
      rstn_i   = 1'b0;
      adc_a    = 14'sd1234;
      adc_b    = -14'sd2000;
      gen      = '0;
      slot_ret = '0;
      bus_req  = '0;
      repeat (3) @(posedge clk_i);
      @(negedge clk_i);
      rstn_i = 1'b1;
      @(negedge clk_i);

      // reset defaults
      for (int c = 0; c < CHANS; c++) begin
         exp_src = (c <= SLOTS) ? SLOTS + 2 : (c == SLOTS + 1) ? SLOTS + 3 : 15;
         read_check(dsp_bus_pkg::OFS_IN_SEL, c, exp_src, "in_sel default");
         read_check(dsp_bus_pkg::OFS_OUT_SEL, c, 32'h0, "out_sel default");
      end
      check_sample("pwm_o[0]", pwm[0], '0);
      check_sample("pwm_o[1]", pwm[1], '0);
      check_sample("dat_a_o", dat_a, '0);
      check_sample("dat_b_o", dat_b, '0);
      check_sample("scope_o[0]", scope[0], adc_a);
      check_sample("scope_o[1]", scope[1], adc_b);

      // back to back, unmapped offsets and index
      read_check(16'h0020, 0, 32'h0, "unmapped read");
      read_check(16'h000c, 3, 32'h0, "unmapped read");
      read_check(dsp_bus_pkg::OFS_IN_SEL, 12, 32'h0, "in_sel bad index");

      // source routing per channel
      drive_random();
      write_reg(dsp_bus_pkg::OFS_OUT_SEL, 0, 32'h1);   // slot 0 into dac1
      write_reg(dsp_bus_pkg::OFS_OUT_SEL, 1, 32'h2);   // slot 1 into dac2
      for (int c = 0; c < CHANS; c++) begin
         route_source(c, (c + 5) % SRCS);
      end
      route_source(SLOTS + 2, 15);   // pwm0 off again
      route_source(1, 15);

      // random samples and dac masks
      for (int c = 0; c < DIRECT; c++) begin
         write_reg(dsp_bus_pkg::OFS_OUT_SEL, c, $random(seed));
      end
      for (int it = 0; it < RAND_IT; it++) begin
         if (it % 16 == 0) begin
            write_reg(dsp_bus_pkg::OFS_OUT_SEL, {$random(seed)} % DIRECT, $random(seed));
         end
         drive_random();
         @(negedge clk_i);
      end

      // clipping, dac1 gets all six, dac2 the first two
      for (int c = 0; c < DIRECT; c++) begin
         write_reg(dsp_bus_pkg::OFS_OUT_SEL, c, (c < 2) ? 3 : 1);
      end
      fill_direct(14'sd3000);   // only dac1 leaves the range
      check_sample("dat_a_o", dat_a, dsp_sig_pkg::sample_t'(SMAX));
      check_sample("dat_b_o", dat_b, dsp_sig_pkg::sample_t'(2 * 3000));
      read_check(dsp_bus_pkg::OFS_SAT, 0, 32'h1, "sat flags");
      fill_direct(dsp_sig_pkg::sample_t'(SMIN));
      check_sample("dat_a_o", dat_a, dsp_sig_pkg::sample_t'(SMIN));
      check_sample("dat_b_o", dat_b, dsp_sig_pkg::sample_t'(SMIN));
      read_check(dsp_bus_pkg::OFS_SAT, 0, 32'h3, "sat flags");
      fill_direct(14'sd100);   // 600 and 200 stay in range
      read_check(dsp_bus_pkg::OFS_SAT, 0, 32'h0, "sat flags");
      @(negedge clk_i);

      $display("errors: %0d", errors);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

   // watchdog, run length plus half again
   initial begin
      #(RUN_CYCLES * 8 * 3 / 2);
      $display("timeout: the run did not finish within %0d cycles", RUN_CYCLES * 3 / 2);
      $display("errors: %0d", errors);
      $display("Checks failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
dsp_sig_pkg.sv
dsp_bus_pkg.sv
dsp_ctrl_regs.sv
dsp_source_mux.sv
dsp_dac_sum.sv
dsp_router.sv
tb_dsp_router.sv
